// File: logic/vproc_isa_pkg.sv
package vproc_isa_pkg;

    // major opcodes, insn[6:0]
    localparam logic [6:0] OPC_LOAD  = 7'h07;
    localparam logic [6:0] OPC_STORE = 7'h27;
    localparam logic [6:0] OPC_OP    = 7'h57;

    // minor types carried in funct3 of the op major
    localparam logic [2:0] OPIVV = 3'd0;
    localparam logic [2:0] OPIVI = 3'd3;
    localparam logic [2:0] OPCFG = 3'd7;

    // integer funct6 codes
    localparam logic [5:0] F6_ADD = 6'b000000;
    localparam logic [5:0] F6_SUB = 6'b000010;
    localparam logic [5:0] F6_AND = 6'b001001;
    localparam logic [5:0] F6_OR  = 6'b001010;
    localparam logic [5:0] F6_XOR = 6'b001011;

    // element width, the vsew code of vtype
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_t;

    // low bit of each field in the instruction word
    localparam int VD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int VS1_LSB    = 15;
    localparam int VS2_LSB    = 20;
    localparam int FUNCT6_LSB = 26;
    localparam int VTYPE_LSB  = 20;
    // vsew sits at vtype[5:3]
    localparam int VSEW_OFS   = 3;

endpackage

// File: logic/vproc_pipe_pkg.sv
package vproc_pipe_pkg;

    // what an instruction does once past decode
    typedef enum logic [1:0] {
        KIND_NONE  = 2'd0,
        KIND_ALU   = 2'd1,
        KIND_LOAD  = 2'd2,
        KIND_STORE = 2'd3
    } insn_kind_t;

    // lane operation
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_t;

endpackage

// File: logic/vproc_decode.sv
module vproc_decode #(
    parameter int NUM_VEC = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [31:0]                insn_in,
    input  logic                       wb_en,
    input  logic [4:0]                 wb_addr,
    output logic                       proc_rdy,
    output vproc_pipe_pkg::insn_kind_t d_kind,
    output vproc_pipe_pkg::alu_op_t    d_alu_op,
    output logic                       d_imm_mode,
    output vproc_isa_pkg::sew_t        d_sew,
    output logic [4:0]                 d_vs1,
    output logic [4:0]                 d_vs2,
    output logic [4:0]                 d_vd,
    output logic [4:0]                 d_imm
);
    logic [31:0]                f_insn;
    logic                       run;
    logic [6:0]                 f_opcode;
    logic [2:0]                 f_funct3;
    logic [5:0]                 f_funct6;
    logic [4:0]                 f_vs1;
    logic [4:0]                 f_vs2;
    logic [4:0]                 f_vd;
    logic [2:0]                 f_vsew;
    vproc_pipe_pkg::insn_kind_t f_kind;
    vproc_pipe_pkg::alu_op_t    f_alu_op;
    logic                       f_cfg;
    logic                       f_imm_mode;
    logic                       f_writes;
    vproc_isa_pkg::sew_t        sew;
    logic [NUM_VEC-1:0]         sb;
    logic [NUM_VEC-1:0]         sb_next;
    logic                       stall;

    // fetch register, holds while stalled
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            run    <= 1'b0;
            f_insn <= '0;
        end else begin
            run <= 1'b1;
            if (proc_rdy) begin
                f_insn <= insn_in;
            end
        end
    end

    // field split
    assign f_opcode = f_insn[6:0];
    assign f_funct3 = f_insn[vproc_isa_pkg::FUNCT3_LSB +: 3];
    assign f_funct6 = f_insn[vproc_isa_pkg::FUNCT6_LSB +: 6];
    assign f_vs1    = f_insn[vproc_isa_pkg::VS1_LSB +: 5];
    assign f_vs2    = f_insn[vproc_isa_pkg::VS2_LSB +: 5];
    assign f_vd     = f_insn[vproc_isa_pkg::VD_LSB +: 5];
    assign f_vsew   = f_insn[vproc_isa_pkg::VTYPE_LSB + vproc_isa_pkg::VSEW_OFS +: 3];

    // classify, anything unknown stays kind none
    always_comb begin
        f_kind   = vproc_pipe_pkg::KIND_NONE;
        f_alu_op = vproc_pipe_pkg::ALU_ADD;
        f_cfg    = 1'b0;
        case (f_opcode)
            // mop is funct6[1:0], unit stride only
            vproc_isa_pkg::OPC_LOAD: begin
                if (f_funct6[1:0] == 2'b00) begin
                    f_kind = vproc_pipe_pkg::KIND_LOAD;
                end
            end
            vproc_isa_pkg::OPC_STORE: begin
                if (f_funct6[1:0] == 2'b00) begin
                    f_kind = vproc_pipe_pkg::KIND_STORE;
                end
            end
            vproc_isa_pkg::OPC_OP: begin
                if (f_funct3 == vproc_isa_pkg::OPCFG) begin
                    f_cfg = 1'b1;
                end else if (f_funct3 == vproc_isa_pkg::OPIVV ||
                             f_funct3 == vproc_isa_pkg::OPIVI) begin
                    f_kind = vproc_pipe_pkg::KIND_ALU;
                    case (f_funct6)
                        vproc_isa_pkg::F6_ADD: f_alu_op = vproc_pipe_pkg::ALU_ADD;
                        vproc_isa_pkg::F6_SUB: f_alu_op = vproc_pipe_pkg::ALU_SUB;
                        vproc_isa_pkg::F6_AND: f_alu_op = vproc_pipe_pkg::ALU_AND;
                        vproc_isa_pkg::F6_OR:  f_alu_op = vproc_pipe_pkg::ALU_OR;
                        vproc_isa_pkg::F6_XOR: f_alu_op = vproc_pipe_pkg::ALU_XOR;
                        default:               f_kind   = vproc_pipe_pkg::KIND_NONE;
                    endcase
                end
            end
            default: ;
        endcase
    end

    assign f_imm_mode = (f_kind == vproc_pipe_pkg::KIND_ALU) &&
                        (f_funct3 == vproc_isa_pkg::OPIVI);
    assign f_writes   = (f_kind == vproc_pipe_pkg::KIND_ALU) ||
                        (f_kind == vproc_pipe_pkg::KIND_LOAD);

    // raw on vs1/vs2/store data, waw on own vd
    // a load right behind a store would raise ready in the store's valid cycle
    assign stall = (f_kind == vproc_pipe_pkg::KIND_ALU && !f_imm_mode && sb[f_vs1]) ||
                   (f_kind == vproc_pipe_pkg::KIND_ALU && sb[f_vs2]) ||
                   ((f_writes || f_kind == vproc_pipe_pkg::KIND_STORE) && sb[f_vd]) ||
                   (f_kind == vproc_pipe_pkg::KIND_LOAD && d_kind == vproc_pipe_pkg::KIND_STORE);

    assign proc_rdy = run && !stall;

    // set beats clear when a new writer lands on a retiring reg
    always_comb begin
        sb_next = sb;
        if (wb_en) begin
            sb_next[wb_addr] = 1'b0;
        end
        if (!stall && f_writes) begin
            sb_next[f_vd] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sb     <= '0;
            sew    <= vproc_isa_pkg::SEW_8;
            d_kind <= vproc_pipe_pkg::KIND_NONE;
        end else begin
            sb     <= sb_next;
            // bubble into D on stall
            d_kind <= stall ? vproc_pipe_pkg::KIND_NONE : f_kind;
            // sew 64 and reserved codes leave sew alone
            if (f_cfg && f_vsew <= 3'd2) begin
                sew <= vproc_isa_pkg::sew_t'(f_vsew[1:0]);
            end
        end
    end

    // sew sampled before a vsetvli in fetch updates it
    always_ff @(posedge clk) begin
        d_alu_op   <= f_alu_op;
        d_imm_mode <= f_imm_mode;
        d_sew      <= sew;
        d_vs1      <= f_vs1;
        d_vs2      <= f_vs2;
        d_vd       <= f_vd;
        d_imm      <= f_vs1;
    end

endmodule

// File: logic/vproc_vrf.sv
module vproc_vrf #(
    parameter int VLEN    = 64,
    parameter int NUM_VEC = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rd_addr_a,
    input  logic [4:0]      rd_addr_b,
    output logic [VLEN-1:0] rd_data_a,
    output logic [VLEN-1:0] rd_data_b,
    input  logic            wb_en,
    input  logic [4:0]      wb_addr,
    input  logic [VLEN-1:0] wb_data
);
    logic [VLEN-1:0] regs [NUM_VEC];

    // async reads, no bypass
    // the scoreboard keeps readers out until the write edge has passed
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_VEC; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

endmodule

// File: logic/vproc_operand.sv
module vproc_operand #(
    parameter int VLEN = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    input  vproc_pipe_pkg::insn_kind_t d_kind,
    input  vproc_pipe_pkg::alu_op_t    d_alu_op,
    input  logic                       d_imm_mode,
    input  vproc_isa_pkg::sew_t        d_sew,
    input  logic [4:0]                 d_vs1,
    input  logic [4:0]                 d_vs2,
    input  logic [4:0]                 d_vd,
    input  logic [4:0]                 d_imm,
    output logic [4:0]                 rd_addr_a,
    output logic [4:0]                 rd_addr_b,
    input  logic [VLEN-1:0]            rd_data_a,
    input  logic [VLEN-1:0]            rd_data_b,
    output vproc_pipe_pkg::insn_kind_t e_kind,
    output logic [4:0]                 e_vd,
    output vproc_pipe_pkg::alu_op_t    e_alu_op,
    output vproc_isa_pkg::sew_t        e_sew,
    output logic [VLEN-1:0]            e_opa,
    output logic [VLEN-1:0]            e_opb,
    output logic                       mem_port_ready_out
);
    logic            d_mem;
    logic [VLEN-1:0] imm_rep;

    // port a reads vd for memory ops
    // store data, or the old contents kept if a load gets no response
    assign d_mem     = (d_kind == vproc_pipe_pkg::KIND_LOAD) ||
                       (d_kind == vproc_pipe_pkg::KIND_STORE);
    assign rd_addr_a = d_mem ? d_vd : d_vs1;
    assign rd_addr_b = d_vs2;

    // simm5 sign extended per element then copied over the vector
    always_comb begin
        case (d_sew)
            vproc_isa_pkg::SEW_8:  imm_rep = {(VLEN/8){{3{d_imm[4]}}, d_imm}};
            vproc_isa_pkg::SEW_16: imm_rep = {(VLEN/16){{11{d_imm[4]}}, d_imm}};
            default:               imm_rep = {(VLEN/32){{27{d_imm[4]}}, d_imm}};
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            e_kind             <= vproc_pipe_pkg::KIND_NONE;
            mem_port_ready_out <= 1'b0;
        end else begin
            e_kind             <= d_kind;
            // ready for the whole E cycle of a load
            mem_port_ready_out <= (d_kind == vproc_pipe_pkg::KIND_LOAD);
        end
    end

    always_ff @(posedge clk) begin
        // a store has no dest, its slot carries the rs1 address
        e_vd     <= (d_kind == vproc_pipe_pkg::KIND_STORE) ? d_vs1 : d_vd;
        e_alu_op <= d_alu_op;
        e_sew    <= d_sew;
        e_opa    <= d_imm_mode ? imm_rep : rd_data_a;
        e_opb    <= rd_data_b;
    end

endmodule

// File: logic/vproc_alu_lane.sv
module vproc_alu_lane #(
    parameter int LANE_WIDTH = 32
) (
    input  logic                    clk,
    input  logic                    rst,
    input  vproc_pipe_pkg::alu_op_t alu_op,
    input  vproc_isa_pkg::sew_t     sew,
    input  logic [LANE_WIDTH-1:0]   opa,
    input  logic [LANE_WIDTH-1:0]   opb,
    output logic [LANE_WIDTH-1:0]   res
);
    localparam int NB = LANE_WIDTH / 8;

    logic                  is_sub;
    logic [LANE_WIDTH-1:0] arith;
    logic [LANE_WIDTH-1:0] next_res;

    assign is_sub = (alu_op == vproc_pipe_pkg::ALU_SUB);

    // byte wide ripple, chain broken at every element head
    // sub is vs2 + ~opa + 1, the +1 entering at the head
    always_comb begin : byte_chain
        logic       carry;
        logic       head;
        logic [8:0] byte_sum;
        carry = 1'b0;
        for (int b = 0; b < NB; b++) begin
            case (sew)
                vproc_isa_pkg::SEW_8:  head = 1'b1;
                vproc_isa_pkg::SEW_16: head = (b % 2) == 0;
                default:               head = (b % 4) == 0;
            endcase
            byte_sum = {1'b0, opb[8*b +: 8]} +
                       {1'b0, opa[8*b +: 8] ^ {8{is_sub}}} +
                       {8'd0, head ? is_sub : carry};
            arith[8*b +: 8] = byte_sum[7:0];
            carry = byte_sum[8];
        end
    end

    always_comb begin
        case (alu_op)
            vproc_pipe_pkg::ALU_AND: next_res = opa & opb;
            vproc_pipe_pkg::ALU_OR:  next_res = opa | opb;
            vproc_pipe_pkg::ALU_XOR: next_res = opa ^ opb;
            default:                 next_res = arith;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            res <= '0;
        end else begin
            res <= next_res;
        end
    end

endmodule

// File: logic/vproc_retire.sv
module vproc_retire #(
    parameter int VLEN = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    input  vproc_pipe_pkg::insn_kind_t e_kind,
    input  logic [4:0]                 e_vd,
    input  logic [VLEN-1:0]            e_opa,
    input  logic [VLEN-1:0]            lane_res,
    input  logic [VLEN-1:0]            mem_port_in,
    input  logic                       mem_port_valid_in,
    output logic                       wb_en,
    output logic [4:0]                 wb_addr,
    output logic [VLEN-1:0]            wb_data,
    output logic [VLEN-1:0]            mem_port_out,
    output logic [4:0]                 mem_port_addr_out,
    output logic                       mem_port_valid_out
);
    vproc_pipe_pkg::insn_kind_t r_kind;
    logic [4:0]                 r_vd;
    logic [VLEN-1:0]            ld_data;

    // kind and vd delayed one cycle to sit beside the lane results
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            r_kind             <= vproc_pipe_pkg::KIND_NONE;
            mem_port_valid_out <= 1'b0;
        end else begin
            r_kind             <= e_kind;
            // single cycle store strobe
            mem_port_valid_out <= (e_kind == vproc_pipe_pkg::KIND_STORE);
        end
    end

    always_ff @(posedge clk) begin
        r_vd    <= e_vd;
        // no response, old vd comes back so the write leaves it unchanged
        ld_data <= mem_port_valid_in ? mem_port_in : e_opa;
        if (e_kind == vproc_pipe_pkg::KIND_STORE) begin
            mem_port_out      <= e_opa;
            mem_port_addr_out <= e_vd;
        end
    end

    // every alu op and load retires, which also frees its scoreboard bit
    assign wb_en   = (r_kind == vproc_pipe_pkg::KIND_ALU) ||
                     (r_kind == vproc_pipe_pkg::KIND_LOAD);
    assign wb_addr = r_vd;
    assign wb_data = (r_kind == vproc_pipe_pkg::KIND_LOAD) ? ld_data : lane_res;

endmodule

// File: logic/rvv_proc_main.sv
module rvv_proc_main #(
    parameter int VLEN       = 64,
    parameter int LANE_WIDTH = 32,
    parameter int NUM_VEC    = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     insn_in,
    input  logic [VLEN-1:0] mem_port_in,
    input  logic            mem_port_valid_in,
    output logic            mem_port_ready_out,
    output logic [VLEN-1:0] mem_port_out,
    output logic [4:0]      mem_port_addr_out,
    output logic            mem_port_valid_out,
    output logic            proc_rdy
);
    localparam int NUM_LANES = VLEN / LANE_WIDTH;

    // decode to operand
    vproc_pipe_pkg::insn_kind_t d_kind;
    vproc_pipe_pkg::alu_op_t    d_alu_op;
    logic                       d_imm_mode;
    vproc_isa_pkg::sew_t        d_sew;
    logic [4:0]                 d_vs1;
    logic [4:0]                 d_vs2;
    logic [4:0]                 d_vd;
    logic [4:0]                 d_imm;

    // register file reads
    logic [4:0]                 rd_addr_a;
    logic [4:0]                 rd_addr_b;
    logic [VLEN-1:0]            rd_data_a;
    logic [VLEN-1:0]            rd_data_b;

    // execute stage
    vproc_pipe_pkg::insn_kind_t e_kind;
    logic [4:0]                 e_vd;
    vproc_pipe_pkg::alu_op_t    e_alu_op;
    vproc_isa_pkg::sew_t        e_sew;
    logic [VLEN-1:0]            e_opa;
    logic [VLEN-1:0]            e_opb;
    logic [VLEN-1:0]            lane_res;

    // writeback, also clears the scoreboard
    logic                       wb_en;
    logic [4:0]                 wb_addr;
    logic [VLEN-1:0]            wb_data;

    vproc_decode #(.NUM_VEC(NUM_VEC)) u_decode (
        .clk(clk), .rst(rst), .insn_in(insn_in), .wb_en(wb_en), .wb_addr(wb_addr),
        .proc_rdy(proc_rdy), .d_kind(d_kind), .d_alu_op(d_alu_op), .d_imm_mode(d_imm_mode),
        .d_sew(d_sew), .d_vs1(d_vs1), .d_vs2(d_vs2), .d_vd(d_vd), .d_imm(d_imm)
    );

    vproc_vrf #(.VLEN(VLEN), .NUM_VEC(NUM_VEC)) u_vrf (
        .clk(clk), .rst(rst), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    vproc_operand #(.VLEN(VLEN)) u_operand (
        .clk(clk), .rst(rst), .d_kind(d_kind), .d_alu_op(d_alu_op), .d_imm_mode(d_imm_mode),
        .d_sew(d_sew), .d_vs1(d_vs1), .d_vs2(d_vs2), .d_vd(d_vd), .d_imm(d_imm),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .e_kind(e_kind), .e_vd(e_vd), .e_alu_op(e_alu_op), .e_sew(e_sew),
        .e_opa(e_opa), .e_opb(e_opb), .mem_port_ready_out(mem_port_ready_out)
    );

    // one lane per LANE_WIDTH slice
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        vproc_alu_lane #(.LANE_WIDTH(LANE_WIDTH)) u_lane (
            .clk(clk), .rst(rst), .alu_op(e_alu_op), .sew(e_sew),
            .opa(e_opa[g*LANE_WIDTH +: LANE_WIDTH]),
            .opb(e_opb[g*LANE_WIDTH +: LANE_WIDTH]),
            .res(lane_res[g*LANE_WIDTH +: LANE_WIDTH])
        );
    end

    vproc_retire #(.VLEN(VLEN)) u_retire (
        .clk(clk), .rst(rst), .e_kind(e_kind), .e_vd(e_vd), .e_opa(e_opa),
        .lane_res(lane_res), .mem_port_in(mem_port_in), .mem_port_valid_in(mem_port_valid_in),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .mem_port_out(mem_port_out), .mem_port_addr_out(mem_port_addr_out),
        .mem_port_valid_out(mem_port_valid_out)
    );

endmodule

// File: tb/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // reset low for two rising edges
    initial begin
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b1;
    end

endmodule

// File: tb/rvv_proc_main_assert.sv
module rvv_proc_main_assert #(
    parameter int VLEN = 64
) (
    input logic            clk,
    input logic            rst,
    input logic            proc_rdy,
    input logic            mem_port_ready_out,
    input logic            mem_port_valid_out,
    input logic [VLEN-1:0] mem_port_out
);
    timeunit 1ns;
    timeprecision 100ps;

    // outputs quiet while in reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst |-> (!proc_rdy && !mem_port_valid_out && !mem_port_ready_out))
        else $error("outputs active during reset");

    // load ready and store valid never overlap
    a_port_excl: assert property (@(posedge clk) disable iff (!rst)
        !(mem_port_valid_out && mem_port_ready_out))
        else $error("store valid and load ready high together");

    // store data fully known when strobed
    a_store_known: assert property (@(posedge clk) disable iff (!rst)
        mem_port_valid_out |-> !$isunknown(mem_port_out))
        else $error("store data has unknown bits");

endmodule

bind rvv_proc_main rvv_proc_main_assert #(.VLEN(VLEN)) u_assert (
    .clk(clk), .rst(rst), .proc_rdy(proc_rdy),
    .mem_port_ready_out(mem_port_ready_out), .mem_port_valid_out(mem_port_valid_out),
    .mem_port_out(mem_port_out)
);

// File: tb/rvv_proc_main_tb.sv
module rvv_proc_main_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int VLEN = 64;
    localparam int TO   = 200;

    logic            clk;
    logic            rst;
    logic [31:0]     insn_in;
    logic [VLEN-1:0] mem_port_in;
    logic            mem_port_valid_in;
    logic            mem_port_ready_out;
    logic [VLEN-1:0] mem_port_out;
    logic [4:0]      mem_port_addr_out;
    logic            mem_port_valid_out;
    logic            proc_rdy;

    int              errors;
    int              seed = 32'h38d2;
    int              cyc;
    int              acc_cyc;
    int              rdy_low;
    logic [VLEN-1:0] exp_reg [32];
    logic [VLEN-1:0] ld_q [$];
    logic [VLEN-1:0] st_data [$];
    logic [4:0]      st_addr [$];
    int              st_cyc [$];

    tb_clock u_clock (.clk(clk), .rst(rst));

    rvv_proc_main #(.VLEN(VLEN), .LANE_WIDTH(32), .NUM_VEC(32)) UUT (
        .clk(clk), .rst(rst), .insn_in(insn_in), .mem_port_in(mem_port_in),
        .mem_port_valid_in(mem_port_valid_in), .mem_port_ready_out(mem_port_ready_out),
        .mem_port_out(mem_port_out), .mem_port_addr_out(mem_port_addr_out),
        .mem_port_valid_out(mem_port_valid_out), .proc_rdy(proc_rdy)
    );

    always @(posedge clk) cyc <= cyc + 1;

    // memory model: answer every ready cycle from the load queue
    always begin
        @(posedge clk);
        #1;
        if (mem_port_ready_out && ld_q.size() > 0) begin
            mem_port_valid_in = 1'b1;
            mem_port_in       = ld_q.pop_front();
        end else begin
            mem_port_valid_in = 1'b0;
        end
    end

    // store strobes and stall cycles, sampled mid cycle
    always @(negedge clk) begin
        if (mem_port_valid_out) begin
            st_data.push_back(mem_port_out);
            st_addr.push_back(mem_port_addr_out);
            st_cyc.push_back(cyc);
        end
        if (rst && !proc_rdy) begin
            rdy_low = rdy_low + 1;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s, errors: %0d", what, errors);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // move to the drive point just after a rising edge
    task automatic sync();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] enc_vv(input logic [5:0] f6, input logic [4:0] vd,
                                           input logic [4:0] vs2, input logic [4:0] vs1);
        return (32'(f6) << vproc_isa_pkg::FUNCT6_LSB) | (32'(1) << 25) |
               (32'(vs2) << vproc_isa_pkg::VS2_LSB) | (32'(vs1) << vproc_isa_pkg::VS1_LSB) |
               (32'(vproc_isa_pkg::OPIVV) << vproc_isa_pkg::FUNCT3_LSB) |
               (32'(vd) << vproc_isa_pkg::VD_LSB) | 32'(vproc_isa_pkg::OPC_OP);
    endfunction

    function automatic logic [31:0] enc_vi(input logic [5:0] f6, input logic [4:0] vd,
                                           input logic [4:0] vs2, input logic [4:0] imm);
        // immediate sits in the vs1 field
        return (enc_vv(f6, vd, vs2, imm) & ~(32'h7 << vproc_isa_pkg::FUNCT3_LSB)) |
               (32'(vproc_isa_pkg::OPIVI) << vproc_isa_pkg::FUNCT3_LSB);
    endfunction

    function automatic logic [31:0] enc_mem(input logic [6:0] opc, input logic [4:0] vd,
                                            input logic [4:0] rs1);
        return (32'(rs1) << vproc_isa_pkg::VS1_LSB) | (32'(vd) << vproc_isa_pkg::VD_LSB) |
               32'(opc);
    endfunction

    function automatic logic [31:0] enc_cfg(input logic [2:0] vsew);
        return (32'(vsew) << (vproc_isa_pkg::VTYPE_LSB + vproc_isa_pkg::VSEW_OFS)) |
               (32'(vproc_isa_pkg::OPCFG) << vproc_isa_pkg::FUNCT3_LSB) |
               32'(vproc_isa_pkg::OPC_OP);
    endfunction

    // simm5 sign extended into each w-bit element
    function automatic logic [63:0] rep_imm(input logic [4:0] imm, input int w);
        logic [63:0] mask;
        logic [63:0] res;
        mask = (w == 32) ? 64'hffff_ffff : ((64'h1 << w) - 1);
        res  = '0;
        for (int i = 0; i < 64 / w; i++) begin
            res = res | (({{59{imm[4]}}, imm} & mask) << (i * w));
        end
        return res;
    endfunction

    // element-wise reference, each element wraps on its own
    function automatic logic [63:0] vec_op(input logic [5:0] f6, input logic [63:0] vs2,
                                           input logic [63:0] src, input int w);
        logic [63:0] mask;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] r;
        logic [63:0] res;
        mask = (w == 32) ? 64'hffff_ffff : ((64'h1 << w) - 1);
        res  = '0;
        for (int i = 0; i < 64 / w; i++) begin
            ea = (vs2 >> (i * w)) & mask;
            eb = (src >> (i * w)) & mask;
            case (f6)
                vproc_isa_pkg::F6_SUB: r = ea - eb;
                vproc_isa_pkg::F6_AND: r = ea & eb;
                vproc_isa_pkg::F6_OR:  r = ea | eb;
                vproc_isa_pkg::F6_XOR: r = ea ^ eb;
                default:               r = ea + eb;
            endcase
            res = res | ((r & mask) << (i * w));
        end
        return res;
    endfunction

    // hold insn until accepted, leaves insn_in at zero
    task automatic issue(input logic [31:0] insn);
        int n;
        n       = 0;
        insn_in = insn;
        while (!proc_rdy && n < TO) begin
            sync();
            n++;
        end
        if (!proc_rdy) begin
            abort_run("proc_rdy stayed low");
        end else begin
            sync();
            acc_cyc = cyc;
            insn_in = 32'h0;
        end
    endtask

    task automatic wait_store(input int count);
        int n;
        n = 0;
        while (st_data.size() < count && n < TO) begin
            @(negedge clk);
            n++;
        end
        if (st_data.size() < count) begin
            abort_run("no store strobe");
        end else begin
            sync();
        end
    endtask

    task automatic store_check(input logic [4:0] vd, input logic [4:0] rs1);
        int n0;
        n0 = st_data.size();
        issue(enc_mem(vproc_isa_pkg::OPC_STORE, vd, rs1));
        wait_store(n0 + 1);
        check("mem_port_out", st_data[n0], exp_reg[vd]);
        check("mem_port_addr_out", 64'(st_addr[n0]), 64'(rs1));
    endtask

    task automatic load_reg(input logic [4:0] vd, input logic [4:0] rs1);
        logic [63:0] word;
        word = {$random(seed), $random(seed)};
        ld_q.push_back(word);
        exp_reg[vd] = word;
        issue(enc_mem(vproc_isa_pkg::OPC_LOAD, vd, rs1));
    endtask

    task automatic alu_vv(input logic [5:0] f6, input logic [4:0] vd, input logic [4:0] vs2,
                          input logic [4:0] vs1, input int w);
        exp_reg[vd] = vec_op(f6, exp_reg[vs2], exp_reg[vs1], w);
        issue(enc_vv(f6, vd, vs2, vs1));
    endtask

    task automatic alu_vi(input logic [5:0] f6, input logic [4:0] vd, input logic [4:0] vs2,
                          input logic [4:0] imm, input int w);
        exp_reg[vd] = vec_op(f6, exp_reg[vs2], rep_imm(imm, w), w);
        issue(enc_vi(f6, vd, vs2, imm));
    endtask

    task automatic test_reset();
        // sampled before the first edge out of reset
        check("proc_rdy", 64'(proc_rdy), 64'd0);
        check("mem_port_valid_out", 64'(mem_port_valid_out), 64'd0);
        check("mem_port_ready_out", 64'(mem_port_ready_out), 64'd0);
        sync();
        store_check(5'd5, 5'd9);
    endtask

    task automatic test_load_store();
        for (int i = 1; i <= 4; i++) begin
            load_reg(5'(i), 5'(i));
        end
        for (int i = 1; i <= 4; i++) begin
            store_check(5'(i), 5'(16 + i));
        end
    endtask

    task automatic test_vv();
        logic [5:0] ops [5];
        ops = '{vproc_isa_pkg::F6_ADD, vproc_isa_pkg::F6_SUB, vproc_isa_pkg::F6_AND,
                vproc_isa_pkg::F6_OR, vproc_isa_pkg::F6_XOR};
        issue(enc_cfg(3'd2));
        for (int k = 0; k < 5; k++) begin
            alu_vv(ops[k], 5'(6 + k), 5'd1, 5'd2, 32);
            store_check(5'(6 + k), 5'(6 + k));
        end
    endtask

    task automatic test_vi();
        // sew 8, negative immediates
        issue(enc_cfg(3'd0));
        alu_vi(vproc_isa_pkg::F6_ADD, 5'd12, 5'd3, 5'h1d, 8);
        alu_vi(vproc_isa_pkg::F6_XOR, 5'd13, 5'd3, 5'h1f, 8);
        store_check(5'd12, 5'd12);
        store_check(5'd13, 5'd13);
        // sew 16
        issue(enc_cfg(3'd1));
        alu_vi(vproc_isa_pkg::F6_ADD, 5'd14, 5'd4, 5'h19, 16);
        alu_vi(vproc_isa_pkg::F6_AND, 5'd15, 5'd4, 5'h10, 16);
        store_check(5'd14, 5'd14);
        store_check(5'd15, 5'd15);
    endtask

    task automatic test_raw();
        int n;
        int drops;
        issue(enc_cfg(3'd2));
        rdy_low = 0;
        n       = 0;
        // second op reads v20 right after it is written
        alu_vv(vproc_isa_pkg::F6_ADD, 5'd20, 5'd1, 5'd2, 32);
        alu_vv(vproc_isa_pkg::F6_SUB, 5'd21, 5'd20, 5'd3, 32);
        // only the dependent op sits in fetch here
        while (!proc_rdy && n < TO) begin
            sync();
            n++;
        end
        if (!proc_rdy) begin
            abort_run("dependent op never left fetch");
        end else begin
            drops = rdy_low;
            store_check(5'd21, 5'd21);
            store_check(5'd20, 5'd20);
            if (drops == 0) begin
                $display("proc_rdy never dropped during the dependent sequence");
                errors = errors + 1;
            end
        end
    endtask

    task automatic test_store_timing();
        int n0;
        n0 = st_data.size();
        issue(enc_mem(vproc_isa_pkg::OPC_STORE, 5'd1, 5'd3));
        wait_store(n0 + 1);
        check("store edge offset", 64'(st_cyc[n0] - acc_cyc), 64'd3);
        check("mem_port_valid_out", 64'(mem_port_valid_out), 64'd0);
        repeat (3) sync();
        check("store strobe count", 64'(st_data.size()), 64'(n0 + 1));
    endtask

    initial begin
        int n;
        insn_in           = 32'h0;
        mem_port_in       = '0;
        mem_port_valid_in = 1'b0;
        errors            = 0;
        cyc               = 0;
        rdy_low           = 0;
        n                 = 0;
        for (int i = 0; i < 32; i++) begin
            exp_reg[i] = '0;
        end
        while (rst !== 1'b1 && n < TO) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b1) begin
            abort_run("reset never released");
        end else begin
            test_reset();
            test_load_store();
            test_vv();
            test_vi();
            test_raw();
            test_store_timing();
            repeat (4) sync();
            $display("errors: %0d", errors);
            if (errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

    // whole-run limit
    initial begin
        #100000;
        abort_run("simulation limit reached");
    end

endmodule

// File: rvv_proc_main.f
logic/vproc_isa_pkg.sv
logic/vproc_pipe_pkg.sv
logic/vproc_decode.sv
logic/vproc_vrf.sv
logic/vproc_operand.sv
logic/vproc_alu_lane.sv
logic/vproc_retire.sv
logic/rvv_proc_main.sv
tb/tb_clock.sv
tb/rvv_proc_main_assert.sv
tb/rvv_proc_main_tb.sv

// File: Makefile
# Verilator build and run for the vector pipeline testbench
VERILATOR ?= verilator
TOP       ?= rvv_proc_main_tb
FILELIST  ?= rvv_proc_main.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
